/* common/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    //////////////////////////////
    // geometry
    //////////////////////////////
    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 128;
    localparam int LINE_WORDS = 8;

    typedef logic [6:0]   set_idx_t;
    typedef logic [19:0]  tag_t;
    typedef logic [3:0]   way_mask_t;
    typedef logic [255:0] line_t;
    typedef logic [127:0] half_t;
    typedef logic [2:0]   plru_t;

    // valid sits in the low bit
    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        RUN,
        MISS,
        REFILL,
        FINISH,
        RECOVER
    } cache_state_e;

endpackage

`default_nettype wire

/* common/axi_rd_pkg.sv */
`default_nettype none

package axi_rd_pkg;

    // eight beats per line
    localparam logic [3:0] RD_LEN = 4'd7;

    // 4-byte beats
    localparam logic [2:0] RD_SIZE = 3'd2;

    localparam logic [1:0] RD_BURST_WRAP = 2'b10;

    // refill port id
    localparam logic [3:0] ICACHE_RD_ID = 4'd3;

endpackage

`default_nettype wire

/* common/icache_array_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface icache_array_if import icache_pkg::*; ();

    // address and write side
    set_idx_t  index;
    way_mask_t wen;
    logic      wvalid;
    tag_t      wtag;
    line_t     wline;

    // per-way read data, one cycle after the index
    tagv_t     rtagv [NUM_WAYS];
    line_t     rline [NUM_WAYS];

    modport ctrl (output index, wen, wvalid);

    modport fill (output wtag, wline);

    modport array (
        input  index, wen, wvalid, wtag, wline,
        output rtagv, rline
    );

    modport lookup (input rtagv, rline);

endinterface

`default_nettype wire

/* icache/icache_arrays.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_arrays import icache_pkg::*; (
    input  logic          clk,
    icache_array_if.array arr
);

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        tagv_t tagv_mem [NUM_SETS];
        line_t line_mem [NUM_SETS];
        tagv_t tagv_q;
        line_t line_q;

        // write or read, never both
        always_ff @(posedge clk) begin
            if (arr.wen[w]) begin
                tagv_mem[arr.index] <= '{tag: arr.wtag, valid: arr.wvalid};
                line_mem[arr.index] <= arr.wline;
            end else begin
                tagv_q <= tagv_mem[arr.index];
                line_q <= line_mem[arr.index];
            end
        end

        assign arr.rtagv[w] = tagv_q;
        assign arr.rline[w] = line_q;
    end

endmodule

`default_nettype wire

/* rtl/icache_plru.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_plru import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      plru_lookup,
    input  logic      plru_commit,
    input  set_idx_t  set_index,
    output way_mask_t victim
);
    plru_t     tree [NUM_SETS];
    plru_t     cur;
    way_mask_t pick;

    assign cur = tree[set_index];

    // bit 0 picks the pair, bit 1 or 2 the way
    always_comb begin
        if (!cur[0]) begin
            pick = cur[1] ? 4'b0010 : 4'b0001;
        end else begin
            pick = cur[2] ? 4'b1000 : 4'b0100;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            victim <= '0;
        end else if (plru_lookup) begin
            victim <= pick;
        end
    end

    // point away from the refilled way
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                tree[i] <= '0;
            end
        end else if (plru_commit) begin
            case (victim)
                4'b0001: tree[set_index] <= {cur[2], 2'b11};
                4'b0010: tree[set_index] <= {cur[2], 2'b01};
                4'b0100: tree[set_index] <= {1'b1, cur[1], 1'b0};
                4'b1000: tree[set_index] <= {1'b0, cur[1], 1'b0};
                default: tree[set_index] <= cur;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/icache_refill.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_refill import icache_pkg::*, axi_rd_pkg::*; #(
    parameter logic [3:0] RD_ID = ICACHE_RD_ID
) (
    input  logic         clk,
    input  logic         rst,
    input  cache_state_e state,
    input  tag_t         sda_tag,
    input  set_idx_t     sda_index,
    input  logic         sda_half,
    output logic [31:0]  araddr,
    output logic [3:0]   arid,
    output logic [3:0]   arlen,
    output logic [2:0]   arsize,
    output logic [1:0]   arburst,
    output logic         arvalid,
    input  logic         arready,
    input  logic [3:0]   rid,
    input  logic [31:0]  rdata,
    input  logic         rlast,
    input  logic         rvalid,
    output logic         rready,
    output logic         last_beat,
    output logic         fill_hit,
    output half_t        fill_half,
    icache_array_if.fill arr
);
    logic [31:0] line_buf [LINE_WORDS];
    line_t       line_flat;
    tag_t        fill_tag;
    set_idx_t    fill_set;
    logic [2:0]  beat_cnt;
    logic        beat_ok;

    // wrap burst from the missing half
    assign araddr  = {sda_tag, sda_index, sda_half, 4'b0000};
    assign arid    = RD_ID;
    assign arlen   = RD_LEN;
    assign arsize  = RD_SIZE;
    assign arburst = RD_BURST_WRAP;
    assign arvalid = (state == MISS);
    assign rready  = (state == REFILL);

    assign beat_ok   = rready && rvalid && (rid == RD_ID);
    assign last_beat = beat_ok && rlast;

    always_ff @(posedge clk) begin
        if (!rst) begin
            beat_cnt <= '0;
        end else if (arvalid && arready) begin
            beat_cnt <= {sda_half, 2'b00};
        end else if (beat_ok) begin
            beat_cnt <= beat_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            fill_tag <= sda_tag;
            fill_set <= sda_index;
        end
        if (beat_ok) begin
            line_buf[beat_cnt] <= rdata;
        end
    end

    always_comb begin
        for (int i = 0; i < LINE_WORDS; i++) begin
            line_flat[i*32 +: 32] = line_buf[i];
        end
    end

    assign arr.wtag  = fill_tag;
    assign arr.wline = line_flat;

    // hand the missing half straight back
    assign fill_hit  = (state == FINISH) && (fill_set == sda_index) && (fill_tag == sda_tag);
    assign fill_half = sda_half ? line_flat[255:128] : line_flat[127:0];

endmodule

`default_nettype wire

/* icache/icache_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_pipe import icache_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           inst_req,
    input  logic [7:0]     inst_index,
    input  tag_t           inst_tag,
    output half_t          inst_rdata,
    output logic           inst_index_ok,
    output logic           inst_data_ok,
    input  cache_state_e   state,
    input  logic           fill_hit,
    input  half_t          fill_half,
    output logic           sda_req,
    output set_idx_t       sda_index,
    output logic           sda_half,
    output tag_t           sda_tag,
    output logic           hit,
    output logic           accept,
    output set_idx_t       sin_index,
    output set_idx_t       sta_index,
    icache_array_if.lookup arr
);
    logic       sin_half;
    logic       advance;
    logic       sta_req;
    set_idx_t   sta_index_q;
    logic       sta_half;
    tag_t       sta_tag;
    tagv_t      sda_tagv [NUM_WAYS];
    line_t      sda_line [NUM_WAYS];
    way_mask_t  hit_way;
    logic [1:0] hit_loc;
    line_t      hit_line;
    half_t      hit_half;

    //////////////////////////////
    // index stage
    //////////////////////////////
    assign sin_index = inst_index[7:1];
    assign sin_half  = inst_index[0];

    // data stage empty or finishing this cycle
    assign advance       = !sda_req || inst_data_ok;
    assign inst_index_ok = (state != RESET) && inst_req && advance;
    assign accept        = inst_index_ok;

    // an empty tag stage presents the incoming index
    assign sta_index = sta_req ? sta_index_q : sin_index;

    always_ff @(posedge clk) begin
        if (!rst) begin
            sta_req <= 1'b0;
            sda_req <= 1'b0;
        end else if (advance) begin
            sta_req <= accept;
            sda_req <= sta_req;
        end
    end

    //////////////////////////////
    // tag and data stages
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            sta_index_q <= sin_index;
            sta_half    <= sin_half;
            sta_tag     <= inst_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            sda_index <= sta_index_q;
            sda_half  <= sta_half;
            sda_tag   <= sta_tag;
            sda_tagv  <= arr.rtagv;
            sda_line  <= arr.rline;
        end else if (state == IDLE) begin
            // re-read after a fill
            sda_tagv <= arr.rtagv;
            sda_line <= arr.rline;
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_cmp
        assign hit_way[w] = sda_tagv[w].valid && (sda_tagv[w].tag == sda_tag);
    end

    assign hit_loc  = {hit_way[3] | hit_way[2], hit_way[3] | hit_way[1]};
    assign hit_line = sda_line[hit_loc];
    assign hit_half = sda_half ? hit_line[255:128] : hit_line[127:0];

    assign hit          = sda_req && (|hit_way) && (state == RUN);
    assign inst_data_ok = sda_req && (hit || fill_hit);
    assign inst_rdata   = fill_hit ? fill_half : hit_half;

endmodule

`default_nettype wire

/* icache/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          sda_req,
    input  set_idx_t      sda_index,
    input  logic          hit,
    input  logic          accept,
    input  set_idx_t      sin_index,
    input  set_idx_t      sta_index,
    input  way_mask_t     victim,
    input  logic          arready,
    input  logic          last_beat,
    output cache_state_e  state,
    output logic          plru_lookup,
    output logic          plru_commit,
    icache_array_if.ctrl  arr
);
    set_idx_t sweep_cnt;
    logic     miss;

    assign miss = (state == RUN) && sda_req && !hit;

    //////////////////////////////
    // main FSM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= RESET;
        end else begin
            case (state)
                RESET:   state <= (sweep_cnt == set_idx_t'(NUM_SETS - 1)) ? IDLE : RESET;
                IDLE:    state <= RUN;
                RUN:     state <= miss ? MISS : RUN;
                MISS:    state <= arready ? REFILL : MISS;
                REFILL:  state <= last_beat ? FINISH : REFILL;
                FINISH:  state <= RECOVER;
                RECOVER: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // one set per cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            sweep_cnt <= '0;
        end else if (state == RESET) begin
            sweep_cnt <= sweep_cnt + 7'd1;
        end
    end

    //////////////////////////////
    // array steering
    //////////////////////////////
    // recover re-reads whichever request sits in the data stage next
    assign arr.index = (state == RESET)   ? sweep_cnt :
                       (state == FINISH)  ? sda_index :
                       (state == RECOVER) ? (sda_req ? sda_index : sta_index) :
                       accept             ? sin_index : sta_index;

    assign arr.wen    = (state == RESET)  ? '1 :
                        (state == FINISH) ? victim : '0;
    assign arr.wvalid = (state == FINISH);

    assign plru_lookup = miss;
    assign plru_commit = (state == MISS);

endmodule

`default_nettype wire

/* icache/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*, axi_rd_pkg::*; #(
    parameter logic [3:0] RD_ID = ICACHE_RD_ID
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_req,
    input  logic [7:0]  inst_index,
    input  tag_t        inst_tag,
    output half_t       inst_rdata,
    output logic        inst_index_ok,
    output logic        inst_data_ok,
    output logic [3:0]  arid,
    output logic [31:0] araddr,
    output logic [3:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic        arvalid,
    input  logic        arready,
    input  logic [3:0]  rid,
    input  logic [31:0] rdata,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready
);
    cache_state_e state;
    logic         sda_req;
    set_idx_t     sda_index;
    logic         sda_half;
    tag_t         sda_tag;
    logic         hit;
    logic         accept;
    set_idx_t     sin_index;
    set_idx_t     sta_index;
    logic         fill_hit;
    half_t        fill_half;
    logic         last_beat;
    logic         plru_lookup;
    logic         plru_commit;
    way_mask_t    victim;

    icache_array_if u_arr_if ();

    icache_pipe u_pipe (
        .clk           (clk),
        .rst           (rst),
        .inst_req      (inst_req),
        .inst_index    (inst_index),
        .inst_tag      (inst_tag),
        .inst_rdata    (inst_rdata),
        .inst_index_ok (inst_index_ok),
        .inst_data_ok  (inst_data_ok),
        .state         (state),
        .fill_hit      (fill_hit),
        .fill_half     (fill_half),
        .sda_req       (sda_req),
        .sda_index     (sda_index),
        .sda_half      (sda_half),
        .sda_tag       (sda_tag),
        .hit           (hit),
        .accept        (accept),
        .sin_index     (sin_index),
        .sta_index     (sta_index),
        .arr           (u_arr_if.lookup)
    );

    icache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .sda_req     (sda_req),
        .sda_index   (sda_index),
        .hit         (hit),
        .accept      (accept),
        .sin_index   (sin_index),
        .sta_index   (sta_index),
        .victim      (victim),
        .arready     (arready),
        .last_beat   (last_beat),
        .state       (state),
        .plru_lookup (plru_lookup),
        .plru_commit (plru_commit),
        .arr         (u_arr_if.ctrl)
    );

    icache_arrays u_arrays (
        .clk (clk),
        .arr (u_arr_if.array)
    );

    icache_plru u_plru (
        .clk         (clk),
        .rst         (rst),
        .plru_lookup (plru_lookup),
        .plru_commit (plru_commit),
        .set_index   (sda_index),
        .victim      (victim)
    );

    icache_refill #(
        .RD_ID (RD_ID)
    ) u_refill (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .sda_tag   (sda_tag),
        .sda_index (sda_index),
        .sda_half  (sda_half),
        .araddr    (araddr),
        .arid      (arid),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .arvalid   (arvalid),
        .arready   (arready),
        .rid       (rid),
        .rdata     (rdata),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready),
        .last_beat (last_beat),
        .fill_hit  (fill_hit),
        .fill_half (fill_half),
        .arr       (u_arr_if.fill)
    );

endmodule

`default_nettype wire

/* dv/icache_model.svh */
`ifndef ICACHE_MODEL_SVH
`define ICACHE_MODEL_SVH

// per-set tags, valid bits and tree state
logic [19:0] m_tag   [128][4];
bit          m_valid [128][4];
logic [2:0]  m_tree  [128];
int          m_misses;

task automatic model_clear();
    for (int s = 0; s < 128; s++) begin
        m_tree[s] = 3'b000;
        for (int w = 0; w < 4; w++) begin
            m_tag[s][w]   = '0;
            m_valid[s][w] = 1'b0;
        end
    end
    m_misses = 0;
endtask

// fixed mixing function of the whole byte address
function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] x;
    x = (addr ^ 32'h5a5a_1234) * 32'h9e37_79b1;
    return x + {addr[15:0], addr[31:16]};
endfunction

// the four words of one half line, lowest word in the low bits
function automatic logic [127:0] expect_half(input logic [19:0] tag, input logic [6:0] set,
                                             input logic half);
    logic [127:0] h;
    logic [31:0]  base;
    base = {tag, set, 5'b00000};
    for (int i = 0; i < 4; i++) begin
        h[32*i +: 32] = mem_word(base + 32'((half * 4 + i) * 4));
    end
    return h;
endfunction

// lookup in request order, returns 1 on hit
function automatic bit predict_access(input logic [19:0] tag, input logic [6:0] set);
    logic [2:0] t;
    int         way;
    for (int w = 0; w < 4; w++) begin
        if (m_valid[set][w] && m_tag[set][w] == tag) begin
            return 1'b1;
        end
    end
    t   = m_tree[set];
    way = !t[0] ? (t[1] ? 1 : 0) : (t[2] ? 3 : 2);
    case (way)
        0: m_tree[set] = {t[2], 2'b11};
        1: m_tree[set] = {t[2], 2'b01};
        2: m_tree[set] = {1'b1, t[1], 1'b0};
        default: m_tree[set] = {1'b0, t[1], 1'b0};
    endcase
    m_tag[set][way]   = tag;
    m_valid[set][way] = 1'b1;
    m_misses++;
    return 1'b0;
endfunction

`endif

/* dv/tb_icache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    `include "icache_model.svh"

    logic         clk;
    logic         rst;
    logic         inst_req;
    logic [7:0]   inst_index;
    logic [19:0]  inst_tag;
    logic [127:0] inst_rdata;
    logic         inst_index_ok;
    logic         inst_data_ok;
    logic [3:0]   arid;
    logic [31:0]  araddr;
    logic [3:0]   arlen;
    logic [2:0]   arsize;
    logic [1:0]   arburst;
    logic         arvalid;
    logic         arready;
    logic [3:0]   rid;
    logic [31:0]  rdata;
    logic         rlast;
    logic         rvalid;
    logic         rready;

    typedef struct {
        logic [19:0] tag;
        logic [6:0]  set;
        logic        half;
        bit          hit;
        bit          timed;
        bit          drain;
        int          cyc;
    } req_t;

    req_t req_q[$];
    req_t pend_q[$];
    int   err_data;
    int   err_time;
    int   err_bus;
    int   err_other;
    int   bus_reqs;
    int   cyc;
    int   sweep_cyc;
    int   limit;
    bit   in_burst;

    icache_top u_icache_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_req(input logic [6:0] set, input logic [19:0] tag, input logic half,
                           input bit drain);
        req_t r;
        r.set   = set;
        r.tag   = tag;
        r.half  = half;
        r.hit   = 1'b0;
        r.timed = 1'b0;
        r.drain = drain;
        r.cyc   = 0;
        req_q.push_back(r);
    endtask

    //////////////////////////////
    // bus slave
    //////////////////////////////
    task automatic serve_burst();
        int          d;
        logic [31:0] exp_addr;
        logic [31:0] addr;
        logic [2:0]  w;
        d = $urandom % 4;
        repeat (d) begin
            @(posedge clk);
            #1;
        end
        addr = araddr;
        if (pend_q.size() == 0 || pend_q[0].hit) begin
            $display("bus request at %0t without an expected miss", $time);
            err_other++;
        end else begin
            exp_addr = {pend_q[0].tag, pend_q[0].set, pend_q[0].half, 4'b0000};
            if (addr !== exp_addr) begin
                $display("ERR %0t araddr exp %h got %h", $time, exp_addr, addr);
                err_bus++;
            end
        end
        if (arlen !== 4'd7 || arsize !== 3'd2 || arburst !== 2'b10 || arid !== 4'd3) begin
            $display("ERR %0t arlen/arsize/arburst/arid exp 7/2/2/3 got %0d/%0d/%0d/%0d",
                     $time, arlen, arsize, arburst, arid);
            err_bus++;
        end
        bus_reqs++;
        arready = 1'b1;
        @(posedge clk);
        #1;
        arready  = 1'b0;
        in_burst = 1'b1;
        // wrap order from the requested half
        w = {addr[4], 2'b00};
        for (int k = 0; k < 8; k++) begin
            while ($urandom % 3 == 0) begin
                rvalid = 1'b0;
                @(posedge clk);
                #1;
            end
            rvalid = 1'b1;
            rid    = 4'd3;
            rdata  = mem_word({addr[31:5], w, 2'b00});
            rlast  = (k == 7);
            w      = w + 3'd1;
            @(posedge clk);
            #1;
        end
        rvalid   = 1'b0;
        rlast    = 1'b0;
        in_burst = 1'b0;
    endtask

    initial begin
        arready  = 1'b0;
        rvalid   = 1'b0;
        rlast    = 1'b0;
        rid      = '0;
        rdata    = '0;
        in_burst = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (arvalid) serve_burst();
        end
    end

    //////////////////////////////
    // monitor, sampled mid-cycle
    //////////////////////////////
    always @(negedge clk) begin
        req_t   h;
        req_t   r;
        bit     quiet;
        if (rst) begin
            cyc++;
            // nothing in flight and nothing completing
            quiet = (pend_q.size() == 0);
            if (sweep_cyc < 128) begin
                sweep_cyc++;
                if (inst_index_ok || arvalid) begin
                    $display("request or bus activity at %0t during the tag sweep", $time);
                    err_other++;
                end
            end
            if (rready !== in_burst) begin
                $display("ERR %0t rready exp %b got %b", $time, in_burst, rready);
                err_bus++;
            end
            if (inst_data_ok) begin
                if (pend_q.size() == 0) begin
                    $display("data returned at %0t with nothing outstanding", $time);
                    err_other++;
                end else begin
                    h = pend_q.pop_front();
                    if (inst_rdata !== expect_half(h.tag, h.set, h.half)) begin
                        $display("ERR %0t inst_rdata exp %h got %h", $time,
                                 expect_half(h.tag, h.set, h.half), inst_rdata);
                        err_data++;
                    end
                    if (h.timed && cyc != h.cyc + 2) begin
                        $display("ERR %0t inst_data_ok latency exp 2 got %0d", $time,
                                 cyc - h.cyc);
                        err_time++;
                    end
                end
            end
            if (inst_req && inst_index_ok) begin
                r.set   = inst_index[7:1];
                r.half  = inst_index[0];
                r.tag   = inst_tag;
                r.hit   = predict_access(r.tag, r.set);
                r.timed = r.hit && quiet;
                r.cyc   = cyc;
                pend_q.push_back(r);
            end
        end
    end

    always @(posedge clk) begin
        if (cyc > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        logic [6:0] sets [3];
        req_t       cur_req;
        void'($urandom(74924));
        sets = '{7'd0, 7'd64, 7'd127};
        rst = 1'b0;
        inst_req = 1'b0;
        inst_index = '0;
        inst_tag = '0;
        err_data = 0;
        err_time = 0;
        err_bus = 0;
        err_other = 0;
        bus_reqs = 0;
        cyc = 0;
        sweep_cyc = 0;
        limit = 1000000;
        model_clear();

        // miss then hits, both halves, eviction in one set
        add_req(7'd10, 20'h12345, 1'b0, 1'b1);
        add_req(7'd10, 20'h12345, 1'b0, 1'b1);
        add_req(7'd10, 20'h12345, 1'b1, 1'b1);
        add_req(7'd11, 20'habcde, 1'b1, 1'b1);
        add_req(7'd11, 20'habcde, 1'b0, 1'b1);
        add_req(7'd12, 20'h00f00, 1'b1, 1'b1);
        for (int i = 1; i <= 5; i++) add_req(7'd20, 20'(i), 1'b0, 1'b1);
        for (int i = 1; i <= 5; i++) add_req(7'd20, 20'(i), 1'b0, 1'b1);
        for (int i = 0; i < 300; i++) begin
            add_req(sets[$urandom % 3], 20'h100 + 20'($urandom % 5), 1'($urandom), 1'b0);
        end
        limit = req_q.size() * 40 + 200;

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;
        while (req_q.size() > 0) begin
            cur_req    = req_q.pop_front();
            inst_req   = 1'b1;
            inst_index = {cur_req.set, cur_req.half};
            inst_tag   = cur_req.tag;
            do @(negedge clk); while (!inst_index_ok);
            @(posedge clk);
            #1;
            inst_req = 1'b0;
            if (cur_req.drain) begin
                // let the cache go quiet before the next request
                while (pend_q.size() > 0) begin
                    @(posedge clk);
                end
                #1;
            end else if ($urandom % 4 == 0) begin
                repeat ($urandom % 3) @(posedge clk);
                #1;
            end
        end
        while (pend_q.size() > 0) @(posedge clk);
        repeat (10) @(posedge clk);
        if (bus_reqs != m_misses) begin
            $display("ERR %0t bus_reqs exp %0d got %0d", $time, m_misses, bus_reqs);
            err_bus++;
        end
        $display("errors: data %0d timing %0d bus %0d other %0d",
                 err_data, err_time, err_bus, err_other);
        if (err_data + err_time + err_bus + err_other == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* icache_top.f */
+incdir+dv
common/icache_pkg.sv
common/axi_rd_pkg.sv
common/icache_array_if.sv
icache/icache_arrays.sv
rtl/icache_plru.sv
rtl/icache_refill.sv
icache/icache_pipe.sv
icache/icache_ctrl.sv
icache/icache_top.sv
dv/tb_icache.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       ?= tb_icache
FILELIST  ?= icache_top.f
LOG       ?= sim.log
PASS_MSG  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
